/* rtl/sparse_pkg.sv */
package sparse_pkg;

	// Chunk geometry
	localparam int CHUNK_LEN = 32;
	localparam int BEAT_LEN = 8;
	localparam int BEAT_NUM = CHUNK_LEN / BEAT_LEN;

	// Cluster size
	localparam int UNIT_NUM = 4;
	localparam int ACC_BUF_NUM = 4;

	// Data widths
	localparam int ELEM_W = 8;
	localparam int ACC_W = 32;

	typedef logic signed [ELEM_W-1:0] elem_t;
	typedef logic [CHUNK_LEN-1:0] chunk_map_t;
	typedef logic [BEAT_LEN-1:0] beat_map_t;

	// Nonzero elements packed from index 0 upward
	typedef elem_t [BEAT_LEN-1:0] beat_dat_t;

	typedef logic [$clog2(CHUNK_LEN)-1:0] pos_t;
	typedef logic [$clog2(BEAT_NUM)-1:0] beat_idx_t;
	typedef logic [$clog2(UNIT_NUM)-1:0] unit_idx_t;
	typedef logic [$clog2(ACC_BUF_NUM)-1:0] acc_sel_t;
	typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* rtl/chunk_wr_if.sv */
`timescale 1ns/100ps

interface chunk_wr_if;
	import sparse_pkg::*;

	beat_map_t map;
	beat_dat_t dat;
	logic valid;
	// Beat position inside the chunk
	beat_idx_t count;
	// Double buffer bank being written
	logic sel;

	modport src (
		 output map
		,output dat
		,output valid
		,output count
		,output sel
	);

	modport dst (
		 input map
		,input dat
		,input valid
		,input count
		,input sel
	);

endinterface

/* rtl/sparse_chunk_buf.sv */
`timescale 1ns/100ps

module sparse_chunk_buf #(
	 parameter int RD_NUM = 1
)(
	 input logic clk_i
	,input logic rst_n_i

	,chunk_wr_if.dst wr

	,input logic rd_sel_i
	,input sparse_pkg::pos_t rd_pos_i [RD_NUM]
	,output sparse_pkg::elem_t rd_dat_o [RD_NUM]
	,output sparse_pkg::chunk_map_t rd_map_o
);
	import sparse_pkg::*;

	localparam int BIT_W = $clog2(BEAT_LEN);

	// Two banks, one map and one packed data word per beat
	beat_map_t map_q [2][BEAT_NUM];
	beat_dat_t dat_q [2][BEAT_NUM];

	////////////////////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////////////////////

	// Maps are cleared so an unwritten chunk reads as all zero
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int b = 0; b < 2; b++) begin
				for (int k = 0; k < BEAT_NUM; k++) begin
					map_q[b][k] <= '0;
				end
			end
		end else if (wr.valid) begin
			map_q[wr.sel][wr.count] <= wr.map;
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr.valid) begin
			dat_q[wr.sel][wr.count] <= wr.dat;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int k = 0; k < BEAT_NUM; k++) begin
			rd_map_o[k*BEAT_LEN +: BEAT_LEN] = map_q[rd_sel_i][k];
		end
	end

	// Per port: prefix popcount below the addressed bit gives the packed index
	always_comb begin
		beat_idx_t beat;
		logic [BIT_W-1:0] bit_pos;
		logic [BIT_W-1:0] pre_cnt;
		beat_map_t bmap;
		for (int r = 0; r < RD_NUM; r++) begin
			beat = beat_idx_t'(rd_pos_i[r] / BEAT_LEN);
			bit_pos = BIT_W'(rd_pos_i[r] % BEAT_LEN);
			bmap = map_q[rd_sel_i][beat];
			pre_cnt = '0;
			for (int j = 0; j < BEAT_LEN; j++) begin
				if (j < bit_pos) begin
					pre_cnt = pre_cnt + BIT_W'(bmap[j]);
				end
			end
			// zero position reads zero
			if (bmap[bit_pos]) begin
				rd_dat_o[r] = dat_q[rd_sel_i][beat][pre_cnt];
			end else begin
				rd_dat_o[r] = '0;
			end
		end
	end

endmodule

/* rtl/sparse_match_engine.sv */
`timescale 1ns/100ps

module sparse_match_engine (
	 input logic clk_i
	,input logic rst_n_i

	,input logic chunk_start_i
	,input logic run_valid_i

	,input sparse_pkg::chunk_map_t ifm_map_i
	,input sparse_pkg::chunk_map_t filt_map_i

	,output sparse_pkg::pos_t rd_pos_o
	,input sparse_pkg::elem_t ifm_dat_i
	,input sparse_pkg::elem_t filt_dat_i

	,input sparse_pkg::acc_sel_t acc_sel_i

	,output logic add_en_o
	,output sparse_pkg::acc_sel_t add_sel_o
	,output sparse_pkg::acc_t add_val_o

	,output logic chunk_end_o
);
	import sparse_pkg::*;

	// Positions still to be multiplied
	chunk_map_t match_q;
	acc_t psum_q;
	acc_sel_t sel_q;
	// High while idle
	logic end_q;

	logic signed [2*ELEM_W-1:0] prod;
	logic match_empty;

	assign match_empty = (match_q == '0);
	assign prod = ifm_dat_i * filt_dat_i;

	// Priority encoder, lowest set bit wins
	always_comb begin
		rd_pos_o = '0;
		for (int p = CHUNK_LEN - 1; p >= 0; p--) begin
			if (match_q[p]) begin
				rd_pos_o = pos_t'(p);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Chunk FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			match_q <= '0;
			psum_q <= '0;
			sel_q <= '0;
			end_q <= 1'b1;
		end else if (end_q) begin
			// start only taken when idle
			if (chunk_start_i) begin
				match_q <= ifm_map_i & filt_map_i;
				psum_q <= '0;
				sel_q <= acc_sel_i;
				end_q <= 1'b0;
			end
		end else if (run_valid_i) begin
			if (!match_empty) begin
				psum_q <= psum_q + acc_t'(prod);
				// Drop the position just consumed
				match_q <= match_q & (match_q - 1'b1);
			end else begin
				end_q <= 1'b1;
			end
		end
	end

	// Sum goes out in the enabled cycle after the last match
	assign add_en_o = !end_q && run_valid_i && match_empty;
	assign add_sel_o = sel_q;
	assign add_val_o = psum_q;
	assign chunk_end_o = end_q;

endmodule

/* rtl/acc_buf_bank.sv */
`timescale 1ns/100ps

module acc_buf_bank (
	 input logic clk_i
	,input logic rst_n_i

	,input logic clear_i
	,input logic add_en_i
	,input sparse_pkg::acc_sel_t add_sel_i
	,input sparse_pkg::acc_t add_val_i

	,input sparse_pkg::acc_sel_t rd_sel_i
	,output sparse_pkg::acc_t rd_dat_o
);
	import sparse_pkg::*;

	acc_t acc_q [ACC_BUF_NUM];

	// Clear wins over a same-cycle add
	always_ff @(posedge clk_i) begin
		if (!rst_n_i || clear_i) begin
			for (int k = 0; k < ACC_BUF_NUM; k++) begin
				acc_q[k] <= '0;
			end
		end else if (add_en_i) begin
			acc_q[add_sel_i] <= acc_q[add_sel_i] + add_val_i;
		end
	end

	assign rd_dat_o = acc_q[rd_sel_i];

endmodule

/* rtl/compute_unit.sv */
`timescale 1ns/100ps

module compute_unit (
	 input logic clk_i
	,input logic rst_n_i

	,chunk_wr_if.dst filt_wr
	,input logic filt_rd_sel_i

	,input sparse_pkg::chunk_map_t ifm_map_i
	,output sparse_pkg::pos_t ifm_rd_pos_o
	,input sparse_pkg::elem_t ifm_rd_dat_i

	,input logic chunk_start_i
	,input logic run_valid_i
	,input sparse_pkg::acc_sel_t acc_sel_i
	,input logic acc_clear_i
	,input sparse_pkg::acc_sel_t out_buf_sel_i

	,output logic chunk_end_o
	,output sparse_pkg::acc_t out_dat_o
);
	import sparse_pkg::*;

	pos_t rd_pos;
	pos_t filt_rd_pos [1];
	elem_t filt_rd_dat [1];
	chunk_map_t filt_map;

	logic add_en;
	acc_sel_t add_sel;
	acc_t add_val;

	// Same position addresses both operand buffers
	assign filt_rd_pos[0] = rd_pos;
	assign ifm_rd_pos_o = rd_pos;

	sparse_chunk_buf #(
		 .RD_NUM(1)
	) i_filt_buf (
		 .clk_i
		,.rst_n_i
		,.wr(filt_wr)
		,.rd_sel_i(filt_rd_sel_i)
		,.rd_pos_i(filt_rd_pos)
		,.rd_dat_o(filt_rd_dat)
		,.rd_map_o(filt_map)
	);

	sparse_match_engine i_match_engine (
		 .clk_i
		,.rst_n_i
		,.chunk_start_i
		,.run_valid_i
		,.ifm_map_i
		,.filt_map_i(filt_map)
		,.rd_pos_o(rd_pos)
		,.ifm_dat_i(ifm_rd_dat_i)
		,.filt_dat_i(filt_rd_dat[0])
		,.acc_sel_i
		,.add_en_o(add_en)
		,.add_sel_o(add_sel)
		,.add_val_o(add_val)
		,.chunk_end_o
	);

	acc_buf_bank i_acc_buf_bank (
		 .clk_i
		,.rst_n_i
		,.clear_i(acc_clear_i)
		,.add_en_i(add_en)
		,.add_sel_i(add_sel)
		,.add_val_i(add_val)
		,.rd_sel_i(out_buf_sel_i)
		,.rd_dat_o(out_dat_o)
	);

endmodule

/* rtl/compute_cluster.sv */
`timescale 1ns/100ps

module compute_cluster (
	 input logic clk_i
	,input logic rst_n_i

	,input sparse_pkg::beat_map_t ifm_map_i
	,input sparse_pkg::beat_dat_t ifm_dat_i
	,input logic ifm_wr_valid_i
	,input sparse_pkg::beat_idx_t ifm_wr_count_i
	,input logic ifm_wr_sel_i
	,input logic ifm_rd_sel_i

	,input sparse_pkg::beat_map_t filt_map_i
	,input sparse_pkg::beat_dat_t filt_dat_i
	,input logic filt_wr_valid_i
	,input sparse_pkg::beat_idx_t filt_wr_count_i
	,input logic filt_wr_sel_i
	,input logic filt_rd_sel_i
	,input sparse_pkg::unit_idx_t filter_wr_unit_i

	,input logic run_valid_i
	,input logic chunk_start_i
	,input sparse_pkg::acc_sel_t acc_sel_i
	,input logic acc_clear_i
	,output logic chunk_end_o

	,input sparse_pkg::acc_sel_t out_buf_sel_i
	,input sparse_pkg::unit_idx_t out_unit_sel_i
	,output sparse_pkg::acc_t out_dat_o
);
	import sparse_pkg::*;

	chunk_wr_if ifm_wr ();

	pos_t ifm_rd_pos [UNIT_NUM];
	elem_t ifm_rd_dat [UNIT_NUM];
	chunk_map_t ifm_map;

	logic [UNIT_NUM-1:0] unit_end;
	acc_t unit_dat [UNIT_NUM];

	////////////////////////////////////////////////////////////////////////////
	// Shared IFM store, one read port per unit
	////////////////////////////////////////////////////////////////////////////

	assign ifm_wr.map = ifm_map_i;
	assign ifm_wr.dat = ifm_dat_i;
	assign ifm_wr.valid = ifm_wr_valid_i;
	assign ifm_wr.count = ifm_wr_count_i;
	assign ifm_wr.sel = ifm_wr_sel_i;

	sparse_chunk_buf #(
		 .RD_NUM(UNIT_NUM)
	) i_ifm_buf (
		 .clk_i
		,.rst_n_i
		,.wr(ifm_wr)
		,.rd_sel_i(ifm_rd_sel_i)
		,.rd_pos_i(ifm_rd_pos)
		,.rd_dat_o(ifm_rd_dat)
		,.rd_map_o(ifm_map)
	);

	////////////////////////////////////////////////////////////////////////////
	// Unit array
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < UNIT_NUM; i++) begin : gen_unit
		chunk_wr_if filt_wr ();

		assign filt_wr.map = filt_map_i;
		assign filt_wr.dat = filt_dat_i;
		// Only the addressed unit sees the filter write
		assign filt_wr.valid = filt_wr_valid_i && (filter_wr_unit_i == unit_idx_t'(i));
		assign filt_wr.count = filt_wr_count_i;
		assign filt_wr.sel = filt_wr_sel_i;

		compute_unit i_compute_unit (
			 .clk_i
			,.rst_n_i
			,.filt_wr(filt_wr)
			,.filt_rd_sel_i
			,.ifm_map_i(ifm_map)
			,.ifm_rd_pos_o(ifm_rd_pos[i])
			,.ifm_rd_dat_i(ifm_rd_dat[i])
			,.chunk_start_i
			,.run_valid_i
			,.acc_sel_i
			,.acc_clear_i
			,.out_buf_sel_i
			,.chunk_end_o(unit_end[i])
			,.out_dat_o(unit_dat[i])
		);
	end

	// Chunk done only when every unit is done
	assign chunk_end_o = &unit_end;
	assign out_dat_o = unit_dat[out_unit_sel_i];

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen #(
	 parameter int PERIOD_NS = 8
	,parameter int RST_CYCLES = 8
)(
	 output logic clk_o
	,output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Reset released on a rising edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

/* dv/tb_compute_cluster.sv */
`timescale 1ns/100ps

module tb_compute_cluster;
	import sparse_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 8;
	localparam int NCASE = 12;
	localparam int CLR_CASE = 6;
	localparam int WR_BEATS = BEAT_NUM * (UNIT_NUM + 1);
	localparam int RUN_LIMIT = 4 * CHUNK_LEN;
	localparam int WD_CYCLES = RST_CYCLES + 200 + NCASE * 2 * (CHUNK_LEN + 20 + WR_BEATS);

	logic clk;
	logic rst_n;

	beat_map_t ifm_map_i;
	beat_dat_t ifm_dat_i;
	logic ifm_wr_valid_i;
	beat_idx_t ifm_wr_count_i;
	logic ifm_wr_sel_i;
	logic ifm_rd_sel_i;
	beat_map_t filt_map_i;
	beat_dat_t filt_dat_i;
	logic filt_wr_valid_i;
	beat_idx_t filt_wr_count_i;
	logic filt_wr_sel_i;
	logic filt_rd_sel_i;
	unit_idx_t filter_wr_unit_i;
	logic run_valid_i;
	logic chunk_start_i;
	acc_sel_t acc_sel_i;
	logic acc_clear_i;
	logic chunk_end_o;
	acc_sel_t out_buf_sel_i;
	unit_idx_t out_unit_sel_i;
	acc_t out_dat_o;

	// Case table of stimulus and expected chunk sums
	elem_t ifm_tab [NCASE][CHUNK_LEN];
	elem_t filt_tab [NCASE][UNIT_NUM][CHUNK_LEN];
	logic bank_tab [NCASE];
	acc_sel_t sel_tab [NCASE];
	logic [7:0] gap_tab [NCASE];
	acc_t sum_tab [NCASE][UNIT_NUM];
	// Enabled cycles from start to chunk end
	int len_tab [NCASE];

	// Expected accumulators per unit and buffer
	acc_t exp_acc [UNIT_NUM][ACC_BUF_NUM];
	int mis_cnt = 0;
	int oth_cnt = 0;

	clk_gen #(
		 .PERIOD_NS(CLK_PERIOD)
		,.RST_CYCLES(RST_CYCLES)
	) i_clk_gen (
		 .clk_o(clk)
		,.rst_n_o(rst_n)
	);

	compute_cluster i_compute_cluster (
		 .clk_i(clk)
		,.rst_n_i(rst_n)
		,.*
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////////////////////////////////////////

	function automatic elem_t rand_elem(input int pct);
		if ($urandom_range(99) < pct) begin
			return elem_t'($urandom | 1);
		end
		return '0;
	endfunction

	// Sum over positions set in both maps
	function automatic acc_t dot_ref(input int k, input int u);
		acc_t s;
		s = '0;
		for (int p = 0; p < CHUNK_LEN; p++) begin
			if (ifm_tab[k][p] != 0 && filt_tab[k][u][p] != 0) begin
				s += acc_t'(ifm_tab[k][p]) * acc_t'(filt_tab[k][u][p]);
			end
		end
		return s;
	endfunction

	// One enabled cycle per match of the busiest unit plus the closing cycle
	function automatic int end_latency(input int k);
		int best;
		int n;
		best = 0;
		for (int u = 0; u < UNIT_NUM; u++) begin
			n = 0;
			for (int p = 0; p < CHUNK_LEN; p++) begin
				if (ifm_tab[k][p] != 0 && filt_tab[k][u][p] != 0) begin
					n++;
				end
			end
			if (n > best) begin
				best = n;
			end
		end
		return best + 1;
	endfunction

	// Nonzero elements packed from index 0 with one map bit per nonzero
	function automatic void pack_beat(input elem_t ch [CHUNK_LEN], input int b,
		output beat_map_t m, output beat_dat_t d);
		int n;
		n = 0;
		m = '0;
		d = '0;
		for (int j = 0; j < BEAT_LEN; j++) begin
			if (ch[b*BEAT_LEN + j] != 0) begin
				m[j] = 1'b1;
				d[n] = ch[b*BEAT_LEN + j];
				n++;
			end
		end
	endfunction

	task automatic check_acc(input string name, input acc_t got, input acc_t exp);
		if (got !== exp) begin
			mis_cnt++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_end(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mis_cnt++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_all_acc();
		for (int u = 0; u < UNIT_NUM; u++) begin
			for (int b = 0; b < ACC_BUF_NUM; b++) begin
				@(posedge clk);
				out_unit_sel_i <= unit_idx_t'(u);
				out_buf_sel_i <= acc_sel_t'(b);
				@(negedge clk);
				check_acc($sformatf("out_dat_o unit %0d buf %0d", u, b),
					out_dat_o, exp_acc[u][b]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Table setup
	////////////////////////////////////////////////////////////////////////////

	task automatic fill_table();
		for (int k = 0; k < NCASE; k++) begin
			bank_tab[k] = k[0];
			sel_tab[k] = acc_sel_t'($urandom);
			gap_tab[k] = 8'($urandom) | 8'h55;
			for (int p = 0; p < CHUNK_LEN; p++) begin
				ifm_tab[k][p] = rand_elem(40);
				for (int u = 0; u < UNIT_NUM; u++) begin
					filt_tab[k][u][p] = rand_elem(40);
					case (k)
						0: begin
							ifm_tab[k][p] = '0;
							filt_tab[k][u][p] = '0;
						end
						1: begin
							ifm_tab[k][p] = (u == 0) ? rand_elem(100) : ifm_tab[k][p];
							filt_tab[k][u][p] = rand_elem(100);
						end
						// Disjoint maps with IFM on even and filter on odd positions
						2: begin
							ifm_tab[k][p] = p[0] ? elem_t'(0) : elem_t'(7);
							filt_tab[k][u][p] = p[0] ? rand_elem(100) : elem_t'(0);
						end
						3: begin
							ifm_tab[k][p] = -8'sd128;
							case (u)
								0: filt_tab[k][u][p] = -8'sd128;
								1: filt_tab[k][u][p] = 8'sd127;
								2: filt_tab[k][u][p] = p[0] ? 8'sd127 : -8'sd128;
								default: ;
							endcase
						end
						default: ;
					endcase
				end
			end
		end
		gap_tab[1] = 8'hff;
		gap_tab[2] = 8'h55;
		for (int k = 0; k < NCASE; k++) begin
			for (int u = 0; u < UNIT_NUM; u++) begin
				sum_tab[k][u] = dot_ref(k, u);
			end
			len_tab[k] = end_latency(k);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////////////////////

	// Beats go in a rotated order and idle cycles carry junk with valid low
	task automatic write_ifm(input int k);
		beat_map_t m;
		beat_dat_t d;
		int off;
		int b;
		off = $urandom_range(BEAT_NUM - 1);
		for (int j = 0; j < BEAT_NUM; j++) begin
			b = (j * 3 + off) % BEAT_NUM;
			pack_beat(ifm_tab[k], b, m, d);
			@(posedge clk);
			ifm_wr_valid_i <= 1'b1;
			ifm_wr_count_i <= beat_idx_t'(b);
			ifm_wr_sel_i <= bank_tab[k];
			ifm_map_i <= m;
			ifm_dat_i <= d;
			if ($urandom_range(1) == 1) begin
				@(posedge clk);
				ifm_wr_valid_i <= 1'b0;
				ifm_map_i <= beat_map_t'($urandom);
				ifm_dat_i <= {$urandom, $urandom};
			end
		end
		@(posedge clk);
		ifm_wr_valid_i <= 1'b0;
	endtask

	task automatic write_filt(input int k, input int u);
		beat_map_t m;
		beat_dat_t d;
		int off;
		int b;
		off = $urandom_range(BEAT_NUM - 1);
		for (int j = 0; j < BEAT_NUM; j++) begin
			b = (j * 3 + off) % BEAT_NUM;
			pack_beat(filt_tab[k][u], b, m, d);
			@(posedge clk);
			filt_wr_valid_i <= 1'b1;
			filt_wr_count_i <= beat_idx_t'(b);
			filt_wr_sel_i <= bank_tab[k];
			filter_wr_unit_i <= unit_idx_t'(u);
			filt_map_i <= m;
			filt_dat_i <= d;
			if ($urandom_range(1) == 1) begin
				@(posedge clk);
				filt_wr_valid_i <= 1'b0;
				filt_map_i <= beat_map_t'($urandom);
				filt_dat_i <= {$urandom, $urandom};
			end
		end
		@(posedge clk);
		filt_wr_valid_i <= 1'b0;
	endtask

	task automatic write_case(input int k);
		write_ifm(k);
		for (int u = UNIT_NUM - 1; u >= 0; u--) begin
			write_filt(k, u);
		end
	endtask

	// Start pulse followed by run_valid from the case's gap pattern until done
	task automatic run_chunk(input int k);
		int cyc;
		int en_cnt;
		logic exp_end;
		@(posedge clk);
		chunk_start_i <= 1'b1;
		ifm_rd_sel_i <= bank_tab[k];
		filt_rd_sel_i <= bank_tab[k];
		acc_sel_i <= sel_tab[k];
		@(posedge clk);
		chunk_start_i <= 1'b0;
		run_valid_i <= gap_tab[k][0];
		@(negedge clk);
		check_end($sformatf("chunk_end_o after start of case %0d", k), chunk_end_o, 1'b0);
		cyc = 1;
		en_cnt = 0;
		while (chunk_end_o !== 1'b1 && cyc < RUN_LIMIT) begin
			@(posedge clk);
			// Enable level the DUT samples at this edge
			if (run_valid_i) begin
				en_cnt++;
			end
			run_valid_i <= gap_tab[k][cyc % 8];
			cyc++;
			@(negedge clk);
			exp_end = (en_cnt >= len_tab[k]);
			check_end($sformatf("chunk_end_o in case %0d after %0d enabled cycles", k, en_cnt),
				chunk_end_o, exp_end);
		end
		if (chunk_end_o !== 1'b1) begin
			oth_cnt++;
			$display("Case %0d did not reach chunk end within %0d cycles", k, RUN_LIMIT);
		end
		@(posedge clk);
		run_valid_i <= 1'b0;
	endtask

	task automatic clear_all();
		@(posedge clk);
		acc_clear_i <= 1'b1;
		@(posedge clk);
		acc_clear_i <= 1'b0;
		for (int u = 0; u < UNIT_NUM; u++) begin
			for (int b = 0; b < ACC_BUF_NUM; b++) begin
				exp_acc[u][b] = '0;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		ifm_map_i = '0;
		ifm_dat_i = '0;
		ifm_wr_valid_i = 1'b0;
		ifm_wr_count_i = '0;
		ifm_wr_sel_i = 1'b0;
		ifm_rd_sel_i = 1'b0;
		filt_map_i = '0;
		filt_dat_i = '0;
		filt_wr_valid_i = 1'b0;
		filt_wr_count_i = '0;
		filt_wr_sel_i = 1'b0;
		filt_rd_sel_i = 1'b0;
		filter_wr_unit_i = '0;
		run_valid_i = 1'b0;
		chunk_start_i = 1'b0;
		acc_sel_i = '0;
		acc_clear_i = 1'b0;
		out_buf_sel_i = '0;
		out_unit_sel_i = '0;
		for (int u = 0; u < UNIT_NUM; u++) begin
			for (int b = 0; b < ACC_BUF_NUM; b++) begin
				exp_acc[u][b] = '0;
			end
		end
		void'($urandom(32'h641e_f78b));
		fill_table();

		wait (rst_n === 1'b1);
		@(negedge clk);
		check_end("chunk_end_o after reset", chunk_end_o, 1'b1);
		check_all_acc();

		write_case(0);
		for (int k = 0; k < NCASE; k++) begin
			if (k == CLR_CASE) begin
				clear_all();
				check_all_acc();
			end
			// Next case goes into the other bank while this one runs
			fork
				run_chunk(k);
				begin
					if (k + 1 < NCASE) begin
						write_case(k + 1);
					end
				end
			join
			for (int u = 0; u < UNIT_NUM; u++) begin
				exp_acc[u][sel_tab[k]] += sum_tab[k][u];
			end
			check_all_acc();
		end

		$display("Errors: %0d mismatches, %0d other failures", mis_cnt, oth_cnt);
		if (mis_cnt + oth_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("Timeout, run did not finish within %0d cycles", WD_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

/* sparse_cluster.f */
rtl/sparse_pkg.sv
rtl/chunk_wr_if.sv
rtl/sparse_chunk_buf.sv
rtl/sparse_match_engine.sv
rtl/acc_buf_bank.sv
rtl/compute_unit.sv
rtl/compute_cluster.sv
dv/clk_gen.sv
dv/tb_compute_cluster.sv
